/* all.f */
source/mmi_map_pkg.sv
source/symb_rate_pkg.sv
source/mmi_if.sv
source/hold_ctrl_if.sv
source/symb_rate_regs.sv
source/repeat_counter.sv
source/hold_sequencer.sv
source/sample_hold_buffer.sv
source/symb_rate_divider_top.sv
tests/symb_rate_divider_assertions.sv
tests/tb_symb_rate_divider.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run the testbench, decide by the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f all.f \
    --top-module tb_symb_rate_divider -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -qx "TEST PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* source/hold_ctrl_if.sv */
// Control path between the hold sequencer, the repeat counter and the hold buffer

`timescale 1ns/1ps

interface hold_ctrl_if #(
    parameter int SAMPLE_WIDTH = 32
) ();

    import symb_rate_pkg::*;

    // Capture a new sample
    logic load;
    // One repeat consumed
    logic step;
    // One repeat remains
    logic last;

    // Rate latched with the held sample
    symb_rate_sel_t held_sel;

    // Held sample, presented on the output stream
    logic [SAMPLE_WIDTH-1:0] sample;

    modport seq (
        output load, step,
        input  last, held_sel
    );

    modport cnt (
        input  load, step,
        output last
    );

    modport buffer (
        input  load,
        output sample, held_sel
    );

endinterface

/* source/hold_sequencer.sv */
// Stream handshake control, accepts a sample and presents it for its repeat count
// Rate changes only apply to samples accepted after them

`timescale 1ns/1ps

module hold_sequencer (
    input  logic                           clk_mmi,
    input  logic                           sresetn_mmi,
    input  logic                           in_valid,
    output logic                           in_ready,
    output logic                           out_valid,
    input  logic                           out_ready,
    input  symb_rate_pkg::symb_rate_sel_t  rate_sel,
    output symb_rate_pkg::repeat_cnt_t     load_count,
    hold_ctrl_if.seq                       ctrl
);

    import symb_rate_pkg::*;

    typedef enum logic {
        EMPTY,
        HOLDING
    } hold_state_t;

    hold_state_t state;

    logic in_xfer;
    logic out_xfer;
    logic last_rep;

    ////////////////////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////////////////////

    // Full rate samples need no countdown
    assign last_rep = ctrl.last || (ctrl.held_sel == TX_SYMB_RATE_FULL);

    // Output valid the cycle after acceptance
    assign out_valid = (state == HOLDING);

    // Accept when empty or when the last repeat leaves this cycle
    assign in_ready = (state == EMPTY) || (out_ready && last_rep);

    assign in_xfer  = in_valid && in_ready;
    assign out_xfer = out_valid && out_ready;

    assign ctrl.load = in_xfer;
    assign ctrl.step = out_xfer;

    // Repeats after the first, from the incoming rate
    always_comb begin
        load_count = '0;
        for (int i = 0; i < NUM_TX_SYMB_RATES; i++) begin
            if (rate_sel == symb_rate_sel_t'(i)) begin
                load_count = repeat_cnt_t'(REPEAT_FACTOR[i] - 1);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi) begin
            state <= EMPTY;
        end else begin
            case (state)
                EMPTY: begin
                    if (in_xfer) begin
                        state <= HOLDING;
                    end
                end
                HOLDING: begin
                    // Stay when a new sample replaces the last repeat
                    if (out_xfer && last_rep && !in_xfer) begin
                        state <= EMPTY;
                    end
                end
                default: begin
                    state <= EMPTY;
                end
            endcase
        end
    end

endmodule

/* source/mmi_if.sv */
// Simple memory-mapped bus, writes take one cycle, reads answer one cycle later
// Master must not issue a new read while a response is still waiting for rready

`timescale 1ns/1ps

interface mmi_if ();

    import mmi_map_pkg::*;

    // Write channel
    logic      wvalid;
    logic      wready;
    mmi_addr_t waddr;
    mmi_data_t wdata;

    // Read request
    logic      arvalid;
    logic      arready;
    mmi_addr_t raddr;

    // Read response
    logic      rvalid;
    logic      rready;
    mmi_data_t rdata;

    modport master (
        output wvalid, waddr, wdata, arvalid, raddr, rready,
        input  wready, arready, rvalid, rdata
    );

    modport slave (
        input  wvalid, waddr, wdata, arvalid, raddr, rready,
        output wready, arready, rvalid, rdata
    );

endinterface

/* source/mmi_map_pkg.sv */
// Register map of the symbol-rate register block
// Word addressed, 16 words decoded, only the first TOTAL_MMI_REGS are defined

package mmi_map_pkg;

    //////////////////////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////////////////////

    // Word address
    typedef logic [3:0] mmi_addr_t;

    // Register data word
    typedef logic [31:0] mmi_data_t;

    //////////////////////////////////////////////////////////////////////////////
    // Register addresses
    //////////////////////////////////////////////////////////////////////////////

    localparam mmi_addr_t ADDR_MODULE_VERSION = 4'd0;
    localparam mmi_addr_t ADDR_SYMB_RATE_SEL  = 4'd1;
    localparam mmi_addr_t ADDR_SYMB_RATE      = 4'd2;

    // First undefined address, reads from here up return zero
    localparam int TOTAL_MMI_REGS = 3;

    // Read-only version word
    localparam mmi_data_t MODULE_VERSION = 32'd1;

endpackage

/* source/repeat_counter.sv */
// Repeats left for the held sample, zero means the current one is the last

`timescale 1ns/1ps

module repeat_counter (
    input  logic                        clk_mmi,
    input  logic                        sresetn_mmi,
    hold_ctrl_if.cnt                    ctrl,
    input  symb_rate_pkg::repeat_cnt_t  load_count
);

    import symb_rate_pkg::*;

    repeat_cnt_t count;

    // Load wins over step, a new sample can arrive on its predecessor's last repeat
    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi) begin
            count <= '0;
        end else if (ctrl.load) begin
            count <= load_count;
        end else if (ctrl.step && count != '0) begin
            count <= count - repeat_cnt_t'(1);
        end
    end

    // Last repeat being presented
    assign ctrl.last = (count == '0);

endmodule

/* source/sample_hold_buffer.sv */
// Holds the sample under repetition and the rate it was accepted with

`timescale 1ns/1ps

module sample_hold_buffer #(
    parameter int SAMPLE_WIDTH = 32
) (
    input  logic                           clk_mmi,
    input  logic                           sresetn_mmi,
    input  logic [SAMPLE_WIDTH-1:0]        in_data,
    input  symb_rate_pkg::symb_rate_sel_t  rate_sel,
    hold_ctrl_if.buffer                    ctrl
);

    import symb_rate_pkg::*;

    logic [SAMPLE_WIDTH-1:0] sample_q;
    symb_rate_sel_t          sel_q;

    // Sample payload
    always_ff @(posedge clk_mmi) begin
        if (ctrl.load) begin
            sample_q <= in_data;
        end
    end

    // Latched rate, steady until the next sample
    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi) begin
            sel_q <= TX_SYMB_RATE_FULL;
        end else if (ctrl.load) begin
            sel_q <= rate_sel;
        end
    end

    assign ctrl.sample   = sample_q;
    assign ctrl.held_sel = sel_q;

endmodule

/* source/symb_rate_divider_top.sv */
// Transmit symbol-rate divider, repeats each sample 1, 2 or 4 times
// Single clock domain, the register bus and the stream share clk_mmi

`timescale 1ns/1ps

module symb_rate_divider_top #(
    parameter int SAMPLE_WIDTH = 32,
    parameter symb_rate_pkg::symb_rate_table_t SYMB_RATE_MSPS =
        symb_rate_pkg::DEFAULT_SYMB_RATE_MSPS,
    parameter symb_rate_pkg::symb_rate_sel_t DEFAULT_SYMB_RATE_SEL =
        symb_rate_pkg::TX_SYMB_RATE_FULL
) (
    input  logic                        clk_mmi,
    input  logic                        sresetn_mmi,

    // Sample stream in
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [SAMPLE_WIDTH-1:0]     in_data,

    // Sample stream out
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [SAMPLE_WIDTH-1:0]     out_data,

    // Register bus
    input  logic                        mmi_wvalid,
    output logic                        mmi_wready,
    input  mmi_map_pkg::mmi_addr_t      mmi_waddr,
    input  mmi_map_pkg::mmi_data_t      mmi_wdata,
    input  logic                        mmi_arvalid,
    output logic                        mmi_arready,
    input  mmi_map_pkg::mmi_addr_t      mmi_raddr,
    output logic                        mmi_rvalid,
    input  logic                        mmi_rready,
    output mmi_map_pkg::mmi_data_t      mmi_rdata
);

    import symb_rate_pkg::*;

    symb_rate_sel_t rate_sel;
    repeat_cnt_t    load_count;

    mmi_if mmi_bus ();

    hold_ctrl_if #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) hold_ctrl ();

    //////////////////////////////////////////////////////////////////////////////
    // Port to bus mapping
    //////////////////////////////////////////////////////////////////////////////

    assign mmi_bus.wvalid  = mmi_wvalid;
    assign mmi_bus.waddr   = mmi_waddr;
    assign mmi_bus.wdata   = mmi_wdata;
    assign mmi_bus.arvalid = mmi_arvalid;
    assign mmi_bus.raddr   = mmi_raddr;
    assign mmi_bus.rready  = mmi_rready;

    assign mmi_wready  = mmi_bus.wready;
    assign mmi_arready = mmi_bus.arready;
    assign mmi_rvalid  = mmi_bus.rvalid;
    assign mmi_rdata   = mmi_bus.rdata;

    // Held sample drives the output stream
    assign out_data = hold_ctrl.sample;

    //////////////////////////////////////////////////////////////////////////////
    // Submodules
    //////////////////////////////////////////////////////////////////////////////

    symb_rate_regs #(
        .SYMB_RATE_MSPS        (SYMB_RATE_MSPS),
        .DEFAULT_SYMB_RATE_SEL (DEFAULT_SYMB_RATE_SEL)
    ) regs_inst (
        .clk_mmi     (clk_mmi),
        .sresetn_mmi (sresetn_mmi),
        .mmi         (mmi_bus),
        .rate_sel    (rate_sel)
    );

    hold_sequencer seq_inst (
        .clk_mmi     (clk_mmi),
        .sresetn_mmi (sresetn_mmi),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .rate_sel    (rate_sel),
        .load_count  (load_count),
        .ctrl        (hold_ctrl)
    );

    repeat_counter cnt_inst (
        .clk_mmi     (clk_mmi),
        .sresetn_mmi (sresetn_mmi),
        .ctrl        (hold_ctrl),
        .load_count  (load_count)
    );

    sample_hold_buffer #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) buf_inst (
        .clk_mmi     (clk_mmi),
        .sresetn_mmi (sresetn_mmi),
        .in_data     (in_data),
        .rate_sel    (rate_sel),
        .ctrl        (hold_ctrl)
    );

endmodule

/* source/symb_rate_pkg.sv */
// Rate definitions of the transmit symbol-rate divider
// Rates are powers of two below the full sample rate, so repeats are 1, 2 or 4

package symb_rate_pkg;

    //////////////////////////////////////////////////////////////////////////////
    // Rate selection
    //////////////////////////////////////////////////////////////////////////////

    localparam int NUM_TX_SYMB_RATES = 3;

    // Rate index, as written to the index register
    typedef logic [1:0] symb_rate_sel_t;

    localparam symb_rate_sel_t TX_SYMB_RATE_QUARTER = 2'd0;
    localparam symb_rate_sel_t TX_SYMB_RATE_HALF    = 2'd1;
    localparam symb_rate_sel_t TX_SYMB_RATE_FULL    = 2'd2;

    //////////////////////////////////////////////////////////////////////////////
    // Repeat factors
    //////////////////////////////////////////////////////////////////////////////

    // Remaining repeats of a held sample, counts down to zero
    typedef logic [1:0] repeat_cnt_t;

    // Output transfers per input sample, indexed by rate
    localparam int REPEAT_FACTOR [0:NUM_TX_SYMB_RATES-1] = '{4, 2, 1};

    //////////////////////////////////////////////////////////////////////////////
    // Rate table
    //////////////////////////////////////////////////////////////////////////////

    // Symbol rates in Msps, indexed by rate
    typedef int symb_rate_table_t [0:NUM_TX_SYMB_RATES-1];

    localparam symb_rate_table_t DEFAULT_SYMB_RATE_MSPS = '{125, 250, 500};

endpackage

/* source/symb_rate_regs.sv */
// Rate registers, index and Msps are coupled and always describe the same rate
// Unlisted rates and out-of-range indexes fall back to the default pair

`timescale 1ns/1ps

module symb_rate_regs #(
    parameter symb_rate_pkg::symb_rate_table_t SYMB_RATE_MSPS =
        symb_rate_pkg::DEFAULT_SYMB_RATE_MSPS,
    parameter symb_rate_pkg::symb_rate_sel_t DEFAULT_SYMB_RATE_SEL =
        symb_rate_pkg::TX_SYMB_RATE_FULL
) (
    input  logic                           clk_mmi,
    input  logic                           sresetn_mmi,
    mmi_if.slave                           mmi,
    output symb_rate_pkg::symb_rate_sel_t  rate_sel
);

    import mmi_map_pkg::*;
    import symb_rate_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Signals
    ////////////////////////////////////////////////////////////////////////////

    // Writable registers
    symb_rate_sel_t sel_reg;
    mmi_data_t      rate_reg;

    // Rate lookup for a written Msps value
    logic           wr_rate_hit;
    symb_rate_sel_t wr_rate_sel;

    // Table rate for a written index
    logic           wr_idx_ok;
    mmi_data_t      wr_idx_rate;

    // Pair restored on any bad write
    localparam mmi_data_t DEFAULT_RATE = mmi_data_t'(SYMB_RATE_MSPS[DEFAULT_SYMB_RATE_SEL]);

    // Bus always ready out of reset
    assign mmi.wready  = sresetn_mmi;
    assign mmi.arready = sresetn_mmi;

    assign rate_sel = sel_reg;

    ////////////////////////////////////////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        wr_rate_hit = 1'b0;
        wr_rate_sel = DEFAULT_SYMB_RATE_SEL;
        wr_idx_ok   = 1'b0;
        wr_idx_rate = DEFAULT_RATE;
        for (int i = 0; i < NUM_TX_SYMB_RATES; i++) begin
            // Msps value found in table
            if (mmi.wdata == mmi_data_t'(SYMB_RATE_MSPS[i])) begin
                wr_rate_hit = 1'b1;
                wr_rate_sel = symb_rate_sel_t'(i);
            end
            // Index in range, upper bits must be clear too
            if (mmi.wdata == mmi_data_t'(i)) begin
                wr_idx_ok   = 1'b1;
                wr_idx_rate = mmi_data_t'(SYMB_RATE_MSPS[i]);
            end
        end
    end

    // Each write updates both registers on the same edge
    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi) begin
            sel_reg  <= DEFAULT_SYMB_RATE_SEL;
            rate_reg <= DEFAULT_RATE;
        end else if (mmi.wvalid) begin
            if (mmi.waddr == ADDR_SYMB_RATE_SEL) begin
                if (wr_idx_ok) begin
                    sel_reg  <= mmi.wdata[1:0];
                    rate_reg <= wr_idx_rate;
                end else begin
                    sel_reg  <= DEFAULT_SYMB_RATE_SEL;
                    rate_reg <= DEFAULT_RATE;
                end
            end else if (mmi.waddr == ADDR_SYMB_RATE) begin
                if (wr_rate_hit) begin
                    sel_reg  <= wr_rate_sel;
                    rate_reg <= mmi.wdata;
                end else begin
                    sel_reg  <= DEFAULT_SYMB_RATE_SEL;
                    rate_reg <= DEFAULT_RATE;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read response
    ////////////////////////////////////////////////////////////////////////////

    // Response valid flag, a new request wins over the rready clear
    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi) begin
            mmi.rvalid <= 1'b0;
        end else if (mmi.arvalid) begin
            mmi.rvalid <= 1'b1;
        end else if (mmi.rready) begin
            mmi.rvalid <= 1'b0;
        end
    end

    // Read data, held until the next request
    always_ff @(posedge clk_mmi) begin
        if (mmi.arvalid) begin
            if (int'(mmi.raddr) >= TOTAL_MMI_REGS) begin
                mmi.rdata <= '0;
            end else if (mmi.raddr == ADDR_MODULE_VERSION) begin
                mmi.rdata <= MODULE_VERSION;
            end else if (mmi.raddr == ADDR_SYMB_RATE_SEL) begin
                mmi.rdata <= mmi_data_t'(sel_reg);
            end else begin
                mmi.rdata <= rate_reg;
            end
        end
    end

endmodule

/* tests/symb_rate_divider_assertions.sv */
// Protocol rules of the stream and register bus, bound into the divider top
// Covers output stalls, reset and the read response latency

`timescale 1ns/1ps

module symb_rate_divider_assertions #(
    parameter int SAMPLE_WIDTH = 32
) (
    input logic                    clk_mmi,
    input logic                    sresetn_mmi,
    input logic                    out_valid,
    input logic                    out_ready,
    input logic [SAMPLE_WIDTH-1:0] out_data,
    input logic                    mmi_arvalid,
    input logic                    mmi_rvalid,
    input logic                    mmi_rready
);

    int unsigned assert_failures = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Output stream
    ////////////////////////////////////////////////////////////////////////////

    // Stalled output keeps valid and data
    a_out_stable: assert property (@(posedge clk_mmi) disable iff (!sresetn_mmi)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            assert_failures++;
            $error("out_valid or out_data changed under back-pressure");
        end

    // Nothing leaves while in reset
    a_out_reset: assert property (@(posedge clk_mmi)
        !sresetn_mmi |=> !out_valid)
        else begin
            assert_failures++;
            $error("out_valid high during reset");
        end

    ////////////////////////////////////////////////////////////////////////////
    // Read response
    ////////////////////////////////////////////////////////////////////////////

    a_rvalid_hold: assert property (@(posedge clk_mmi) disable iff (!sresetn_mmi)
        mmi_rvalid && !mmi_rready |=> mmi_rvalid)
        else begin
            assert_failures++;
            $error("rvalid dropped before rready");
        end

    // One cycle latency, both ways
    a_rvalid_after_ar: assert property (@(posedge clk_mmi) disable iff (!sresetn_mmi)
        mmi_arvalid |=> mmi_rvalid)
        else begin
            assert_failures++;
            $error("rvalid missing one cycle after arvalid");
        end

    a_rvalid_rise: assert property (@(posedge clk_mmi) disable iff (!sresetn_mmi)
        $rose(mmi_rvalid) |-> $past(mmi_arvalid))
        else begin
            assert_failures++;
            $error("rvalid rose without a read request");
        end

endmodule

bind symb_rate_divider_top symb_rate_divider_assertions #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH)
) protocol_checks (
    .clk_mmi     (clk_mmi),
    .sresetn_mmi (sresetn_mmi),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data),
    .mmi_arvalid (mmi_arvalid),
    .mmi_rvalid  (mmi_rvalid),
    .mmi_rready  (mmi_rready)
);

/* tests/tb_symb_rate_divider.sv */
// Testbench of the symbol-rate divider, register checks then random stream checks
// Expected samples come from a queue model that follows the rate writes seen on the bus

`timescale 1ns/1ps

module tb_symb_rate_divider;

    import mmi_map_pkg::*;
    import symb_rate_pkg::*;

    localparam int SAMPLE_WIDTH = 32;
    localparam int SEED = 40731;
    localparam int RESET_CYCLES = 8;

    // Stream lengths
    localparam int SAMPLES_PER_RATE = 60;
    localparam int MID_SAMPLES = 80;
    localparam int TOTAL_SAMPLES = 3 * SAMPLES_PER_RATE + MID_SAMPLES;

    // Worst case 4 repeats, with generous slack for random stalls
    localparam int REG_PHASE_CYCLES = 500;
    localparam int CYCLE_LIMIT = TOTAL_SAMPLES * 4 * 3 + REG_PHASE_CYCLES;

    // Rate rules of the register map
    localparam int RATE_MSPS [0:2] = '{125, 250, 500};
    localparam int REPEATS [0:2] = '{4, 2, 1};
    localparam symb_rate_sel_t DEFAULT_SEL = TX_SYMB_RATE_FULL;

    typedef logic [SAMPLE_WIDTH-1:0] sample_t;

    logic      clk_mmi = 1'b0;
    logic      sresetn_mmi;
    logic      in_valid;
    logic      in_ready;
    sample_t   in_data;
    logic      out_valid;
    logic      out_ready;
    sample_t   out_data;
    logic      mmi_wvalid;
    logic      mmi_wready;
    mmi_addr_t mmi_waddr;
    mmi_data_t mmi_wdata;
    logic      mmi_arvalid;
    logic      mmi_arready;
    mmi_addr_t mmi_raddr;
    logic      mmi_rvalid;
    logic      mmi_rready;
    mmi_data_t mmi_rdata;

    // Model state
    sample_t        expected [$];
    symb_rate_sel_t model_sel;
    int             cycle_count = 0;

    symb_rate_divider_top #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) UUT (
        .clk_mmi     (clk_mmi),
        .sresetn_mmi (sresetn_mmi),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_data     (in_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .mmi_wvalid  (mmi_wvalid),
        .mmi_wready  (mmi_wready),
        .mmi_waddr   (mmi_waddr),
        .mmi_wdata   (mmi_wdata),
        .mmi_arvalid (mmi_arvalid),
        .mmi_arready (mmi_arready),
        .mmi_raddr   (mmi_raddr),
        .mmi_rvalid  (mmi_rvalid),
        .mmi_rready  (mmi_rready),
        .mmi_rdata   (mmi_rdata)
    );

    // 20 ns period
    always #10 clk_mmi = ~clk_mmi;

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compares
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_rdata(input string name, input mmi_data_t actual,
                               input mmi_data_t exp_val);
        if (actual !== exp_val) begin
            abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, actual, exp_val));
        end
    endtask

    task automatic check_sample(input string name, input sample_t actual,
                                input sample_t exp_val);
        if (actual !== exp_val) begin
            abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, actual, exp_val));
        end
    endtask

    // Index after a write, by the coupled register rules
    function automatic symb_rate_sel_t sel_after_write(input mmi_addr_t addr,
                                                       input mmi_data_t data,
                                                       input symb_rate_sel_t cur);
        symb_rate_sel_t sel;
        sel = cur;
        if (addr == ADDR_SYMB_RATE_SEL) begin
            sel = (data < 3) ? symb_rate_sel_t'(data) : DEFAULT_SEL;
        end else if (addr == ADDR_SYMB_RATE) begin
            sel = DEFAULT_SEL;
            for (int i = 0; i < 3; i++) begin
                if (data == mmi_data_t'(RATE_MSPS[i])) begin
                    sel = symb_rate_sel_t'(i);
                end
            end
        end
        return sel;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and run limit
    ////////////////////////////////////////////////////////////////////////////

    // Pop before push, a new sample can enter on the last repeat
    always @(posedge clk_mmi) begin
        if (!sresetn_mmi) begin
            model_sel = DEFAULT_SEL;
            expected.delete();
        end else begin
            if (out_valid && out_ready) begin
                if (expected.size() == 0) begin
                    abort_run("Output transfer while no sample was expected");
                end else begin
                    check_sample("out_data", out_data, expected.pop_front());
                end
            end
            if (in_valid && in_ready) begin
                for (int k = 0; k < REPEATS[model_sel]; k++) begin
                    expected.push_back(in_data);
                end
            end
            // Rate write lands on this edge, after the input it races with
            if (mmi_wvalid) begin
                model_sel = sel_after_write(mmi_waddr, mmi_wdata, model_sel);
            end
        end
    end

    always @(posedge clk_mmi) begin
        cycle_count <= cycle_count + 1;
        if (UUT.protocol_checks.assert_failures != 0) begin
            abort_run("A protocol assertion on the DUT failed");
        end else if (cycle_count >= CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout, run not finished after %0d cycles", cycle_count));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_reg(input mmi_addr_t addr, input mmi_data_t data);
        @(posedge clk_mmi);
        mmi_wvalid <= 1'b1;
        mmi_waddr  <= addr;
        mmi_wdata  <= data;
        @(posedge clk_mmi);
        if (!mmi_wready) begin
            abort_run("Register write issued while wready was low");
        end
        mmi_wvalid <= 1'b0;
    endtask

    // Response is held a random number of cycles before rready
    task automatic read_reg(input mmi_addr_t addr, output mmi_data_t data);
        int hold;
        hold = $urandom_range(0, 3);
        @(posedge clk_mmi);
        mmi_arvalid <= 1'b1;
        mmi_raddr   <= addr;
        @(posedge clk_mmi);
        if (!mmi_arready) begin
            abort_run("Read request issued while arready was low");
        end
        mmi_arvalid <= 1'b0;
        do @(posedge clk_mmi); while (!mmi_rvalid);
        repeat (hold) @(posedge clk_mmi);
        mmi_rready <= 1'b1;
        @(posedge clk_mmi);
        if (!mmi_rvalid) begin
            abort_run("Read response dropped before rready");
        end
        data = mmi_rdata;
        mmi_rready <= 1'b0;
    endtask

    task automatic read_and_check(input string name, input mmi_addr_t addr,
                                  input mmi_data_t exp_val);
        mmi_data_t data;
        read_reg(addr, data);
        check_rdata(name, data, exp_val);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stream tasks
    ////////////////////////////////////////////////////////////////////////////

    // Valid stays up with its data until taken
    task automatic stream_samples(input int count);
        int accepted;
        accepted = 0;
        while (accepted < count) begin
            @(posedge clk_mmi);
            if (in_valid && in_ready) begin
                accepted++;
            end
            out_ready <= ($urandom_range(0, 3) != 0);
            if (accepted >= count) begin
                in_valid <= 1'b0;
            end else if (!in_valid || in_ready) begin
                in_valid <= ($urandom_range(0, 3) != 0);
                in_data  <= sample_t'($urandom);
            end
        end
    endtask

    task automatic drain_output();
        out_ready <= 1'b1;
        do @(posedge clk_mmi); while (out_valid);
        if (expected.size() != 0) begin
            abort_run($sformatf("%0d expected samples never came out", expected.size()));
        end
    endtask

    // Rate writes spread over a running stream
    task automatic change_rates_mid_stream();
        repeat (12) @(posedge clk_mmi);
        write_reg(ADDR_SYMB_RATE_SEL, mmi_data_t'(TX_SYMB_RATE_QUARTER));
        repeat (30) @(posedge clk_mmi);
        write_reg(ADDR_SYMB_RATE, 32'd250);
        repeat (25) @(posedge clk_mmi);
        write_reg(ADDR_SYMB_RATE, 32'd500);
        repeat (20) @(posedge clk_mmi);
        write_reg(ADDR_SYMB_RATE_SEL, mmi_data_t'(TX_SYMB_RATE_QUARTER));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        sresetn_mmi <= 1'b0;
        in_valid    <= 1'b0;
        in_data     <= '0;
        out_ready   <= 1'b0;
        mmi_wvalid  <= 1'b0;
        mmi_waddr   <= '0;
        mmi_wdata   <= '0;
        mmi_arvalid <= 1'b0;
        mmi_raddr   <= '0;
        mmi_rready  <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_mmi);
        sresetn_mmi <= 1'b1;
        @(posedge clk_mmi);
        if (!in_ready || out_valid || mmi_rvalid) begin
            abort_run("Stream or read response not idle after reset");
        end

        // Reset values
        read_and_check("version", ADDR_MODULE_VERSION, 32'd1);
        read_and_check("rate_sel", ADDR_SYMB_RATE_SEL, 32'd2);
        read_and_check("rate", ADDR_SYMB_RATE, 32'd500);

        // Index writes, 3 and above fall back
        for (int i = 0; i < 3; i++) begin
            write_reg(ADDR_SYMB_RATE_SEL, mmi_data_t'(i));
            read_and_check("rate_sel", ADDR_SYMB_RATE_SEL, mmi_data_t'(i));
            read_and_check("rate", ADDR_SYMB_RATE, mmi_data_t'(RATE_MSPS[i]));
        end
        write_reg(ADDR_SYMB_RATE_SEL, 32'd3);
        read_and_check("rate_sel", ADDR_SYMB_RATE_SEL, 32'd2);
        read_and_check("rate", ADDR_SYMB_RATE, 32'd500);

        // Rate writes, unlisted rate falls back
        for (int i = 0; i < 3; i++) begin
            write_reg(ADDR_SYMB_RATE, mmi_data_t'(RATE_MSPS[i]));
            read_and_check("rate_sel", ADDR_SYMB_RATE_SEL, mmi_data_t'(i));
            read_and_check("rate", ADDR_SYMB_RATE, mmi_data_t'(RATE_MSPS[i]));
        end
        write_reg(ADDR_SYMB_RATE_SEL, 32'd0);
        write_reg(ADDR_SYMB_RATE, 32'd300);
        read_and_check("rate_sel", ADDR_SYMB_RATE_SEL, 32'd2);
        read_and_check("rate", ADDR_SYMB_RATE, 32'd500);

        // Undefined addresses, a non-default pair shows stray writes
        write_reg(ADDR_SYMB_RATE_SEL, 32'd0);
        write_reg(ADDR_MODULE_VERSION, 32'hffff_ffff);
        for (int a = 3; a < 16; a++) begin
            write_reg(mmi_addr_t'(a), mmi_data_t'($urandom));
            read_and_check($sformatf("rdata[%0d]", a), mmi_addr_t'(a), 32'd0);
        end
        read_and_check("version", ADDR_MODULE_VERSION, 32'd1);
        read_and_check("rate_sel", ADDR_SYMB_RATE_SEL, 32'd0);
        read_and_check("rate", ADDR_SYMB_RATE, 32'd125);

        // One stream per rate
        for (int r = 0; r < 3; r++) begin
            write_reg(ADDR_SYMB_RATE_SEL, mmi_data_t'(r));
            stream_samples(SAMPLES_PER_RATE);
            drain_output();
        end

        // Rate changes while samples are held
        write_reg(ADDR_SYMB_RATE_SEL, mmi_data_t'(TX_SYMB_RATE_FULL));
        fork
            stream_samples(MID_SAMPLES);
            change_rates_mid_stream();
        join
        drain_output();

        if (expected.size() == 0 && UUT.protocol_checks.assert_failures == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("Samples left over or protocol assertion failed at end of run");
        end
    end

endmodule
